/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_hdc_top
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(filter-out +%,$(shell cat $(FLIST)))
HDRS := $(wildcard *.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@$(MAKE) --no-print-directory check LOG=$(LOG)

check:
	@if grep -qF '** FAIL **' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -qF '** PASS **' $(LOG); then echo "no result in $(LOG)"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* hdc_axil_regs.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hdc_cfg.svh"

module hdc_axil_regs import hdc_pkg::*; (
    input  wire logic       AXIS_ACLK,
    input  wire logic       S_AXI_ARESETN,
    input  wire axil_addr_t s_axi_awaddr,
    input  wire logic       s_axi_awvalid,
    output logic            s_axi_awready,
    input  wire axil_word_t s_axi_wdata,
    input  wire logic       s_axi_wvalid,
    output logic            s_axi_wready,
    output logic [1:0]      s_axi_bresp,
    output logic            s_axi_bvalid,
    input  wire logic       s_axi_bready,
    input  wire axil_addr_t s_axi_araddr,
    input  wire logic       s_axi_arvalid,
    output logic            s_axi_arready,
    output axil_word_t      s_axi_rdata,
    output logic [1:0]      s_axi_rresp,
    output logic            s_axi_rvalid,
    input  wire logic       s_axi_rready,
    input  wire logic       gen_done,
    input  wire hv_t        base_vec,
    output logic            run,
    output logic            gen_start,
    output item_cnt_t       item_count,
    output ngram_t          ngram,
    output frame_cnt_t      frame_len
);

    axil_state_e state;
    axil_addr_t  waddr;
    axil_word_t  wdata;
    axil_addr_t  raddr;
    axil_addr_t  wr_off;
    axil_addr_t  rd_off;
    logic        wr_en;
    logic        gen;

    // ====================
    // handshake outputs
    // ====================
    // always OKAY
    assign s_axi_bresp   = 2'b00;
    assign s_axi_rresp   = 2'b00;
    assign s_axi_awready = (state == IDLE) || (state == GOT_W);
    assign s_axi_wready  = (state == IDLE) || (state == GOT_AW);
    // writes win in idle, so hold off ar while a write is offered
    assign s_axi_arready = (state == IDLE) && !s_axi_awvalid && !s_axi_wvalid;
    assign s_axi_bvalid  = (state == WRESP);
    assign s_axi_rvalid  = (state == RD_RESP);

    // word aligned offsets
    assign wr_off = {waddr[`AXIL_ADDR_W-1:2], 2'b00};
    assign rd_off = {raddr[`AXIL_ADDR_W-1:2], 2'b00};

    // state machine
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state <= IDLE;
            wr_en <= 1'b0;
        end else begin
            wr_en <= 1'b0;
            case (state)
                IDLE: begin
                    if (s_axi_awvalid && s_axi_wvalid) begin
                        state <= WRESP;
                        wr_en <= 1'b1;
                    end else if (s_axi_awvalid) begin
                        state <= GOT_AW;
                    end else if (s_axi_wvalid) begin
                        state <= GOT_W;
                    end else if (s_axi_arvalid) begin
                        state <= RD_FETCH;
                    end
                end
                GOT_AW: begin
                    if (s_axi_wvalid) begin
                        state <= WRESP;
                        wr_en <= 1'b1;
                    end
                end
                GOT_W: begin
                    if (s_axi_awvalid) begin
                        state <= WRESP;
                        wr_en <= 1'b1;
                    end
                end
                WRESP: begin
                    if (s_axi_bready) begin
                        state <= IDLE;
                    end
                end
                // one cycle to fetch read data
                RD_FETCH: state <= RD_RESP;
                RD_RESP: begin
                    if (s_axi_rready) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // address and data capture on each handshake
    always_ff @(posedge AXIS_ACLK) begin
        if (s_axi_awvalid && s_axi_awready) begin
            waddr <= s_axi_awaddr;
        end
        if (s_axi_wvalid && s_axi_wready) begin
            wdata <= s_axi_wdata;
        end
        if (s_axi_arvalid && s_axi_arready) begin
            raddr <= s_axi_araddr;
        end
    end

    // ====================
    // register file
    // ====================
    // pulse only on the first wresp cycle
    assign gen_start = wr_en && (wr_off == `REG_CTRL) && wdata[0];

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            run        <= 1'b0;
            gen        <= 1'b0;
            item_count <= '0;
            ngram      <= '0;
            frame_len  <= '0;
        end else if (wr_en) begin
            case (wr_off)
                `REG_CTRL:  {run, gen} <= wdata[1:0];
                `REG_ITEMS: item_count <= wdata[15:0];
                `REG_NGRAM: ngram      <= wdata[3:0];
                `REG_FRAME: frame_len  <= wdata[15:0];
                // base is read only
                default: ;
            endcase
        end else if (gen_done) begin
            // generator finished, gen self-clears
            gen <= 1'b0;
        end
    end

    // read mux, narrow fields zero extended
    always_ff @(posedge AXIS_ACLK) begin
        if (state == RD_FETCH) begin
            case (rd_off)
                `REG_CTRL:  s_axi_rdata <= axil_word_t'({run, gen});
                `REG_ITEMS: s_axi_rdata <= axil_word_t'(item_count);
                `REG_NGRAM: s_axi_rdata <= axil_word_t'(ngram);
                `REG_FRAME: s_axi_rdata <= axil_word_t'(frame_len);
                `REG_BASE:  s_axi_rdata <= axil_word_t'(base_vec);
                default:    s_axi_rdata <= '0;
            endcase
        end
    end

    // ====================
    // checks
    // ====================
    // write and read responses are exclusive
    a_resp_excl: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        !(s_axi_bvalid && s_axi_rvalid));

    // encoder needs a real group length
    a_ngram_run: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        run |-> (ngram != '0));

endmodule

`default_nettype wire

/* hdc_cfg.svh */
`ifndef HDC_CFG_SVH
`define HDC_CFG_SVH

// ====================
// datapath widths
// ====================
`define HDC_DIM      32
`define AXIL_DATA_W  32
`define AXIL_ADDR_W  12

// register map, byte offsets
`define REG_CTRL     12'h000
`define REG_ITEMS    12'h004
`define REG_NGRAM    12'h008
`define REG_FRAME    12'h00C
`define REG_BASE     12'h010

// xorshift32 seed and shift amounts
`define XS_SEED      32'h9E3779B9
`define XS_SH_A      13
`define XS_SH_B      17
`define XS_SH_C      5

`endif

/* hdc_item_gen.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hdc_cfg.svh"

module hdc_item_gen import hdc_pkg::*; (
    input  wire logic      AXIS_ACLK,
    input  wire logic      S_AXI_ARESETN,
    input  wire logic      gen_start,
    input  wire item_cnt_t item_count,
    output logic           gen_done,
    output hv_t            base_vec
);

    hv_t       xs_state;
    item_cnt_t step_cnt;
    logic      busy;
    logic      last_step;

    // one xorshift32 step, shifts applied in order a, b, c
    function automatic hv_t xs_step(input hv_t x);
        hv_t t;
        t = x ^ (x << `XS_SH_A);
        t = t ^ (t >> `XS_SH_B);
        t = t ^ (t << `XS_SH_C);
        return t;
    endfunction

    // all steps taken
    assign last_step = (step_cnt == item_count);

    // step counter and done pulse
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            busy     <= 1'b0;
            gen_done <= 1'b0;
            step_cnt <= '0;
            base_vec <= '0;
        end else begin
            gen_done <= 1'b0;
            if (gen_start) begin
                busy     <= 1'b1;
                step_cnt <= '0;
            end else if (busy) begin
                if (last_step) begin
                    // latch result, tell the regs block
                    busy     <= 1'b0;
                    gen_done <= 1'b1;
                    base_vec <= xs_state;
                end else begin
                    step_cnt <= step_cnt + 16'd1;
                end
            end
        end
    end

    // generator state
    always_ff @(posedge AXIS_ACLK) begin
        if (gen_start) begin
            xs_state <= `XS_SEED;
        end else if (busy && !last_step) begin
            xs_state <= xs_step(xs_state);
        end
    end

endmodule

`default_nettype wire

/* hdc_ngram_encoder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hdc_cfg.svh"

module hdc_ngram_encoder import hdc_pkg::*; (
    input  wire logic   AXIS_ACLK,
    input  wire logic   S_AXI_ARESETN,
    input  wire logic   run,
    input  wire hv_t    base_vec,
    input  wire ngram_t ngram,
    input  wire hv_t    s_axis_tdata,
    input  wire logic   s_axis_tvalid,
    output logic        s_axis_tready,
    input  wire logic   res_ready,
    output logic        res_valid,
    output hv_t         res_data
);

    hv_t    acc;
    hv_t    bound;
    ngram_t beat_cnt;
    logic   pend;
    logic   beat_acc;
    logic   last_beat;
    logic   slot_free;

    // ====================
    // binding datapath
    // ====================
    // rotate left by one, then xor the new item in
    assign bound = {acc[`HDC_DIM-2:0], acc[`HDC_DIM-1]} ^ s_axis_tdata;

    // stall while a finished group waits in acc
    assign s_axis_tready = run && !pend;
    assign beat_acc      = s_axis_tvalid && s_axis_tready;
    assign last_beat     = (beat_cnt == ngram_t'(ngram - 4'd1));
    // result register empty or handing off now
    assign slot_free     = !res_valid || res_ready;

    // control
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            beat_cnt  <= '0;
            pend      <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            if (res_valid && res_ready) begin
                res_valid <= 1'b0;
            end
            if (!run) begin
                beat_cnt <= '0;
                pend     <= 1'b0;
            end else if (pend && slot_free) begin
                // parked group moves out
                pend      <= 1'b0;
                res_valid <= 1'b1;
            end else if (beat_acc) begin
                if (last_beat) begin
                    beat_cnt <= '0;
                    if (slot_free) begin
                        res_valid <= 1'b1;
                    end else begin
                        pend <= 1'b1;
                    end
                end else begin
                    beat_cnt <= beat_cnt + 4'd1;
                end
            end
        end
    end

    // accumulator and result
    always_ff @(posedge AXIS_ACLK) begin
        if (!run) begin
            // idle, track the base so run starts clean
            acc <= base_vec;
        end else if (pend && slot_free) begin
            res_data <= acc;
            acc      <= base_vec;
        end else if (beat_acc) begin
            if (last_beat && slot_free) begin
                res_data <= bound;
                acc      <= base_vec;
            end else begin
                // mid group, or finished group parked
                acc <= bound;
            end
        end
    end

endmodule

`default_nettype wire

/* hdc_pkg.sv */
`default_nettype none

`include "hdc_cfg.svh"

package hdc_pkg;

    // one hypervector, one bit per dimension
    typedef logic [`HDC_DIM-1:0]     hv_t;

    // register bus words
    typedef logic [`AXIL_DATA_W-1:0] axil_word_t;
    typedef logic [`AXIL_ADDR_W-1:0] axil_addr_t;

    // control register fields
    typedef logic [15:0]             item_cnt_t;
    typedef logic [3:0]              ngram_t;
    typedef logic [15:0]             frame_cnt_t;

    // axi4-lite slave states
    // write path can see aw and w in either order
    typedef enum logic [2:0] {
        IDLE, GOT_AW, GOT_W, WRESP, RD_FETCH, RD_RESP
    } axil_state_e;

endpackage

`default_nettype wire

/* hdc_stream_out.sv */
`timescale 1ns/10ps
`default_nettype none

module hdc_stream_out import hdc_pkg::*; (
    input  wire logic       AXIS_ACLK,
    input  wire logic       S_AXI_ARESETN,
    input  wire logic       run,
    input  wire frame_cnt_t frame_len,
    input  wire logic       res_valid,
    input  wire hv_t        res_data,
    output logic            res_ready,
    input  wire logic       m_axis_tready,
    output logic            m_axis_tvalid,
    output hv_t             m_axis_tdata,
    output logic            m_axis_tlast
);

    frame_cnt_t res_cnt;
    logic       take;
    logic       frame_end;

    // slot empty or draining this cycle
    assign res_ready = !m_axis_tvalid || m_axis_tready;
    assign take      = res_valid && res_ready;
    // every frame_len-th result closes a frame
    assign frame_end = (res_cnt == frame_cnt_t'(frame_len - 16'd1));

    // ====================
    // holding register
    // ====================
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            m_axis_tvalid <= 1'b0;
            m_axis_tlast  <= 1'b0;
            res_cnt       <= '0;
        end else begin
            if (take) begin
                m_axis_tvalid <= 1'b1;
                m_axis_tlast  <= frame_end;
            end else if (m_axis_tready) begin
                m_axis_tvalid <= 1'b0;
                m_axis_tlast  <= 1'b0;
            end
            // result counter, restarts while stopped
            if (!run) begin
                res_cnt <= '0;
            end else if (take) begin
                res_cnt <= frame_end ? '0 : res_cnt + 16'd1;
            end
        end
    end

    // payload
    always_ff @(posedge AXIS_ACLK) begin
        if (take) begin
            m_axis_tdata <= res_data;
        end
    end

    // axis rule, beat held until accepted
    a_hold: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        (m_axis_tvalid && !m_axis_tready) |=> (m_axis_tvalid && $stable(m_axis_tdata)));

endmodule

`default_nettype wire

/* hdc_top.sv */
`timescale 1ns/10ps
`default_nettype none

module hdc_top import hdc_pkg::*; (
    input  wire logic       AXIS_ACLK,
    input  wire logic       S_AXI_ARESETN,
    // axi4-lite control
    input  wire axil_addr_t s_axi_awaddr,
    input  wire logic       s_axi_awvalid,
    output logic            s_axi_awready,
    input  wire axil_word_t s_axi_wdata,
    input  wire logic       s_axi_wvalid,
    output logic            s_axi_wready,
    output logic [1:0]      s_axi_bresp,
    output logic            s_axi_bvalid,
    input  wire logic       s_axi_bready,
    input  wire axil_addr_t s_axi_araddr,
    input  wire logic       s_axi_arvalid,
    output logic            s_axi_arready,
    output axil_word_t      s_axi_rdata,
    output logic [1:0]      s_axi_rresp,
    output logic            s_axi_rvalid,
    input  wire logic       s_axi_rready,
    // item stream in
    input  wire hv_t        s_axis_tdata,
    input  wire logic       s_axis_tvalid,
    output logic            s_axis_tready,
    // n-gram stream out
    output hv_t             m_axis_tdata,
    output logic            m_axis_tvalid,
    input  wire logic       m_axis_tready,
    output logic            m_axis_tlast
);

    logic       run;
    logic       gen_start;
    logic       gen_done;
    hv_t        base_vec;
    item_cnt_t  item_count;
    ngram_t     ngram;
    frame_cnt_t frame_len;
    logic       res_valid;
    logic       res_ready;
    hv_t        res_data;

    // ====================
    // input side
    // ====================
    hdc_axil_regs u_regs (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .gen_done      (gen_done),
        .base_vec      (base_vec),
        .run           (run),
        .gen_start     (gen_start),
        .item_count    (item_count),
        .ngram         (ngram),
        .frame_len     (frame_len)
    );

    hdc_item_gen u_item_gen (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .gen_start     (gen_start),
        .item_count    (item_count),
        .gen_done      (gen_done),
        .base_vec      (base_vec)
    );

    // ====================
    // processing and output
    // ====================
    hdc_ngram_encoder u_encoder (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .run           (run),
        .base_vec      (base_vec),
        .ngram         (ngram),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tready (s_axis_tready),
        .res_ready     (res_ready),
        .res_valid     (res_valid),
        .res_data      (res_data)
    );

    hdc_stream_out u_stream_out (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .run           (run),
        .frame_len     (frame_len),
        .res_valid     (res_valid),
        .res_data      (res_data),
        .res_ready     (res_ready),
        .m_axis_tready (m_axis_tready),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tlast  (m_axis_tlast)
    );

endmodule

`default_nettype wire

/* tb_clkgen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clkgen (
    output logic clk,
    output logic rst_n
);

    // 8 ns period
    localparam int HALF_PERIOD = 4;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // low over the first two rising edges, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* tb_hdc_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hdc_cfg.svh"

module tb_hdc_top import hdc_pkg::*; ();

    // cycles per wait and ctrl polls per generation
    localparam int TIMEOUT  = 1000;
    localparam int POLL_MAX = 200;
    localparam int NGRAM    = 3;
    localparam int FRAME    = 4;

    logic       clk;
    logic       rst_n;
    axil_addr_t s_axi_awaddr;
    logic       s_axi_awvalid;
    logic       s_axi_awready;
    axil_word_t s_axi_wdata;
    logic       s_axi_wvalid;
    logic       s_axi_wready;
    logic [1:0] s_axi_bresp;
    logic       s_axi_bvalid;
    logic       s_axi_bready;
    axil_addr_t s_axi_araddr;
    logic       s_axi_arvalid;
    logic       s_axi_arready;
    axil_word_t s_axi_rdata;
    logic [1:0] s_axi_rresp;
    logic       s_axi_rvalid;
    logic       s_axi_rready;
    hv_t        s_axis_tdata;
    logic       s_axis_tvalid;
    logic       s_axis_tready;
    hv_t        m_axis_tdata;
    logic       m_axis_tvalid;
    logic       m_axis_tready;
    logic       m_axis_tlast;

    integer     seed;
    int         checks     = 0;
    int         mismatches = 0;
    int         timeouts   = 0;
    // expected base vector from the xorshift model
    hv_t        base_model;
    hv_t        beats[$];

    tb_clkgen u_clkgen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    hdc_top u_dut (
        .AXIS_ACLK     (clk),
        .S_AXI_ARESETN (rst_n),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tready (s_axis_tready),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .m_axis_tlast  (m_axis_tlast)
    );

    // ====================
    // compare and report
    // ====================
    task automatic check_word(input string name, input axil_word_t got, input axil_word_t exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_hv(input string name, input hv_t got, input hv_t exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("checks %0d, mismatches %0d, timeouts %0d", checks, mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    task automatic timeout_fail(input string what);
        timeouts++;
        $display("Timeout at %0t: %s did not happen in time", $time, what);
        finish_run();
    endtask

    // ====================
    // bus drivers
    // ====================
    // address and data offered together on a falling edge
    task automatic axil_write(input axil_addr_t addr, input axil_word_t data);
        int n;
        @(negedge clk);
        s_axi_awaddr  = addr;
        s_axi_awvalid = 1'b1;
        s_axi_wdata   = data;
        s_axi_wvalid  = 1'b1;
        s_axi_bready  = 1'b1;
        n = 0;
        while (!(s_axi_awready && s_axi_wready)) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) timeout_fail("write address and data ready");
        end
        @(posedge clk);
        @(negedge clk);
        s_axi_awvalid = 1'b0;
        s_axi_wvalid  = 1'b0;
        n = 0;
        while (!s_axi_bvalid) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) timeout_fail("write response");
        end
        check_word("s_axi_bresp", axil_word_t'(s_axi_bresp), '0);
        @(posedge clk);
    endtask

    task automatic axil_read(input axil_addr_t addr, output axil_word_t data);
        int n;
        @(negedge clk);
        s_axi_araddr  = addr;
        s_axi_arvalid = 1'b1;
        s_axi_rready  = 1'b1;
        n = 0;
        while (!s_axi_arready) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) timeout_fail("read address ready");
        end
        @(posedge clk);
        @(negedge clk);
        s_axi_arvalid = 1'b0;
        n = 0;
        while (!s_axi_rvalid) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) timeout_fail("read data");
        end
        data = s_axi_rdata;
        check_word("s_axi_rresp", axil_word_t'(s_axi_rresp), '0);
        @(posedge clk);
    endtask

    task automatic read_check(input axil_addr_t addr, input axil_word_t exp, input string name);
        axil_word_t rd;
        axil_read(addr, rd);
        check_word(name, rd, exp);
    endtask

    // tready changes only on rising edges
    task automatic send_beat(input hv_t data);
        int n;
        @(negedge clk);
        s_axis_tdata  = data;
        s_axis_tvalid = 1'b1;
        n = 0;
        while (!s_axis_tready) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) timeout_fail("s_axis_tready");
        end
        @(posedge clk);
    endtask

    task automatic recv_result(output hv_t data, output logic last);
        int n;
        @(negedge clk);
        m_axis_tready = 1'b1;
        n = 0;
        while (!m_axis_tvalid) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) timeout_fail("m_axis_tvalid");
        end
        data = m_axis_tdata;
        last = m_axis_tlast;
        @(posedge clk);
    endtask

    // ====================
    // reference model
    // ====================
    function automatic hv_t xs_model(input int unsigned steps);
        hv_t         x;
        int unsigned i;
        x = `XS_SEED;
        for (i = 0; i < steps; i++) begin
            x = x ^ (x << `XS_SH_A);
            x = x ^ (x >> `XS_SH_B);
            x = x ^ (x << `XS_SH_C);
        end
        return x;
    endfunction

    // permute by one then bind the next item
    function automatic hv_t ngram_model(input hv_t base, input int first);
        hv_t acc;
        int  i;
        acc = base;
        for (i = 0; i < NGRAM; i++) begin
            acc = ((acc << 1) | (acc >> (`HDC_DIM - 1))) ^ beats[first + i];
        end
        return acc;
    endfunction

    // ====================
    // directed tests
    // ====================
    task automatic gen_check(input item_cnt_t items);
        axil_word_t rd;
        int         polls;
        axil_write(`REG_ITEMS, axil_word_t'(items));
        axil_write(`REG_CTRL, 32'h0000_0001);
        // gen clears itself when the generator is done
        polls = 0;
        rd    = 32'h0000_0001;
        while (rd[0]) begin
            axil_read(`REG_CTRL, rd);
            polls++;
            if (polls > POLL_MAX) timeout_fail("gen bit clear");
        end
        base_model = xs_model(items);
        read_check(`REG_BASE, base_model, "reg_base");
    endtask

    // NGRAM random beats for each expected result
    // the sink holds tready low for stall cycles first
    task automatic run_stream(input int groups, input int stall);
        hv_t  got_d[$];
        logic got_l[$];
        hv_t  d;
        logic l;
        int   i;
        int   k;
        beats.delete();
        for (i = 0; i < groups * NGRAM; i++) begin
            beats.push_back(hv_t'($random(seed)));
        end
        fork
            begin
                for (i = 0; i < beats.size(); i++) begin
                    send_beat(beats[i]);
                end
                @(negedge clk);
                s_axis_tvalid = 1'b0;
            end
            begin
                @(negedge clk);
                m_axis_tready = 1'b0;
                repeat (stall) @(negedge clk);
                for (k = 0; k < groups; k++) begin
                    recv_result(d, l);
                    got_d.push_back(d);
                    got_l.push_back(l);
                    // short gaps after the long stall
                    if (stall > 0 && k % 3 == 1) begin
                        @(negedge clk);
                        m_axis_tready = 1'b0;
                        repeat (2) @(negedge clk);
                    end
                end
                @(negedge clk);
                m_axis_tready = 1'b0;
            end
        join
        // nothing extra may show up
        repeat (10) @(negedge clk);
        check_bit("m_axis_tvalid", m_axis_tvalid, 1'b0);
        for (k = 0; k < groups; k++) begin
            check_hv("m_axis_tdata", got_d[k], ngram_model(base_model, k * NGRAM));
            check_bit("m_axis_tlast", got_l[k], (k % FRAME) == (FRAME - 1));
        end
    endtask

    initial begin
        int n;
        seed          = 32'hbab0;
        s_axi_awaddr  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_araddr  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;
        s_axis_tdata  = '0;
        s_axis_tvalid = 1'b0;
        m_axis_tready = 1'b0;
        base_model    = '0;
        n = 0;
        while (rst_n !== 1'b1) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) timeout_fail("reset release");
        end

        // reset values then readback masked to field widths
        check_bit("m_axis_tvalid", m_axis_tvalid, 1'b0);
        check_bit("m_axis_tlast", m_axis_tlast, 1'b0);
        check_bit("s_axis_tready", s_axis_tready, 1'b0);
        check_bit("s_axi_bvalid", s_axi_bvalid, 1'b0);
        check_bit("s_axi_rvalid", s_axi_rvalid, 1'b0);
        read_check(`REG_CTRL, '0, "reg_ctrl");
        read_check(`REG_ITEMS, '0, "reg_items");
        read_check(`REG_NGRAM, '0, "reg_ngram");
        read_check(`REG_FRAME, '0, "reg_frame");
        read_check(`REG_BASE, '0, "reg_base");
        axil_write(`REG_ITEMS, 32'hFFFF_1234);
        read_check(`REG_ITEMS, 32'h0000_1234, "reg_items");
        axil_write(`REG_NGRAM, 32'hFFFF_FFF5);
        read_check(`REG_NGRAM, 32'h0000_0005, "reg_ngram");
        axil_write(`REG_FRAME, 32'hABCD_0007);
        read_check(`REG_FRAME, 32'h0000_0007, "reg_frame");
        // run set with the gen bit left clear
        axil_write(`REG_CTRL, 32'hFFFF_FFFE);
        read_check(`REG_CTRL, 32'h0000_0002, "reg_ctrl");
        axil_write(`REG_CTRL, '0);
        read_check(`REG_CTRL, '0, "reg_ctrl");

        // base vector generation
        gen_check(16'd5);
        gen_check(16'd0);
        gen_check(16'd100);

        // binding and frame last with a free-running sink
        axil_write(`REG_NGRAM, axil_word_t'(NGRAM));
        axil_write(`REG_FRAME, axil_word_t'(FRAME));
        axil_write(`REG_CTRL, 32'h0000_0002);
        run_stream(8, 0);
        axil_write(`REG_CTRL, '0);

        // restart with a long back-pressure stretch
        axil_write(`REG_CTRL, 32'h0000_0002);
        run_stream(12, 80);
        axil_write(`REG_CTRL, '0);

        finish_run();
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+.
hdc_pkg.sv
hdc_axil_regs.sv
hdc_item_gen.sv
hdc_ngram_encoder.sv
hdc_stream_out.sv
hdc_top.sv
tb_clkgen.sv
tb_hdc_top.sv
